// ==== design/pe_types_pkg.sv ====
package pe_types_pkg;

    // operand widths
    localparam int VALUE_W = 8;
    localparam int COORD_W = 8;

    // full precision, no rounding or saturation
    localparam int PRODUCT_W = 2 * VALUE_W;

    // weight or feature value, two's complement
    typedef logic signed [VALUE_W-1:0] value_t;

    // row or column position
    // offsets reuse this type and wrap modulo 256
    typedef logic signed [COORD_W-1:0] coord_t;

    // value_t times value_t
    typedef logic signed [PRODUCT_W-1:0] product_t;

endpackage

// ==== design/pe_geom_pkg.sv ====
package pe_geom_pkg;

    // weight slots held by the buffer
    localparam int NUM_WEIGHTS = 4;

    // features carried by one beat
    localparam int NUM_FEATURES = 4;

    // slot index width, at least one bit
    localparam int SLOT_W = (NUM_WEIGHTS > 1) ? $clog2(NUM_WEIGHTS) : 1;

    typedef logic [SLOT_W-1:0] slot_t;

endpackage

// ==== design/weight_buffer.sv ====
`timescale 1ns/10ps

module weight_buffer #(
    parameter int NUM_WEIGHTS = pe_geom_pkg::NUM_WEIGHTS
) (
    input  logic                                    clk,
    input  logic                                    rst,

    input  logic                                    weight_valid,
    input  pe_types_pkg::value_t                    weight_value,
    input  pe_types_pkg::coord_t                    weight_row,
    input  pe_types_pkg::coord_t                    weight_col,

    output pe_types_pkg::value_t [NUM_WEIGHTS-1:0]  weight_value_q,
    output pe_types_pkg::coord_t [NUM_WEIGHTS-1:0]  weight_row_q,
    output pe_types_pkg::coord_t [NUM_WEIGHTS-1:0]  weight_col_q,
    output logic                                    weights_full
);

    localparam int SLOT_W = (NUM_WEIGHTS > 1) ? $clog2(NUM_WEIGHTS) : 1;
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_WEIGHTS - 1);

    logic [SLOT_W-1:0] slot_q;
    logic              last_beat;

    // beat that lands in the highest slot
    assign last_beat = weight_valid && (slot_q == LAST_SLOT);

    // slot pointer wraps, fill flag is sticky
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_q       <= '0;
            weights_full <= 1'b0;
        end else begin
            if (weight_valid) begin
                if (last_beat) begin
                    slot_q <= '0;
                end else begin
                    slot_q <= slot_q + 1'b1;
                end
            end
            if (last_beat) begin
                weights_full <= 1'b1;
            end
        end
    end

    // slot storage, written in wrap order
    always_ff @(posedge clk) begin
        if (weight_valid) begin
            weight_value_q[slot_q] <= weight_value;
            weight_row_q[slot_q]   <= weight_row;
            weight_col_q[slot_q]   <= weight_col;
        end
    end

endmodule

// ==== design/pe_cell.sv ====
`timescale 1ns/10ps

module pe_cell (
    input  logic                    clk,
    input  logic                    rst,

    input  pe_types_pkg::value_t    w_value,
    input  pe_types_pkg::value_t    f_value,
    input  pe_types_pkg::coord_t    w_row,
    input  pe_types_pkg::coord_t    w_col,
    input  pe_types_pkg::coord_t    f_row,
    input  pe_types_pkg::coord_t    f_col,

    output pe_types_pkg::product_t  product,
    output pe_types_pkg::coord_t    row_offset,
    output pe_types_pkg::coord_t    col_offset
);

    pe_types_pkg::product_t product_d;
    pe_types_pkg::coord_t   row_d;
    pe_types_pkg::coord_t   col_d;

    always_comb begin
        // signed operands extend to the 16-bit result width
        product_d = w_value * f_value;
        // 8-bit result, overflow wraps
        row_d     = f_row - w_row;
        col_d     = f_col - w_col;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            product    <= '0;
            row_offset <= '0;
            col_offset <= '0;
        end else begin
            product    <= product_d;
            row_offset <= row_d;
            col_offset <= col_d;
        end
    end

endmodule

// ==== design/pe_array.sv ====
`timescale 1ns/10ps

module pe_array #(
    parameter int NUM_WEIGHTS  = pe_geom_pkg::NUM_WEIGHTS,
    parameter int NUM_FEATURES = pe_geom_pkg::NUM_FEATURES
) (
    input  logic                                                        clk,
    input  logic                                                        rst,

    input  logic                                                        feature_valid,
    input  pe_types_pkg::value_t [NUM_FEATURES-1:0]                     feature_value,
    input  pe_types_pkg::coord_t [NUM_FEATURES-1:0]                     feature_row,
    input  pe_types_pkg::coord_t [NUM_FEATURES-1:0]                     feature_col,

    input  pe_types_pkg::value_t [NUM_WEIGHTS-1:0]                      weight_value_q,
    input  pe_types_pkg::coord_t [NUM_WEIGHTS-1:0]                      weight_row_q,
    input  pe_types_pkg::coord_t [NUM_WEIGHTS-1:0]                      weight_col_q,
    input  logic                                                        weights_full,

    output logic                                                        result_valid,
    output pe_types_pkg::product_t [NUM_WEIGHTS-1:0][NUM_FEATURES-1:0]  product,
    output pe_types_pkg::coord_t [NUM_WEIGHTS-1:0][NUM_FEATURES-1:0]    row_offset,
    output pe_types_pkg::coord_t [NUM_WEIGHTS-1:0][NUM_FEATURES-1:0]    col_offset
);

    logic accept;
    logic beat_valid_q;

    pe_types_pkg::value_t [NUM_FEATURES-1:0] feat_value_q;
    pe_types_pkg::coord_t [NUM_FEATURES-1:0] feat_row_q;
    pe_types_pkg::coord_t [NUM_FEATURES-1:0] feat_col_q;

    pe_types_pkg::value_t [NUM_WEIGHTS-1:0]  snap_value_q;
    pe_types_pkg::coord_t [NUM_WEIGHTS-1:0]  snap_row_q;
    pe_types_pkg::coord_t [NUM_WEIGHTS-1:0]  snap_col_q;

    // beats before the buffer fills are dropped
    assign accept = feature_valid && weights_full;

    // stage 1: capture beat and the weights it pairs with
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_valid_q <= 1'b0;
            result_valid <= 1'b0;
            feat_value_q <= '0;
            feat_row_q   <= '0;
            feat_col_q   <= '0;
            snap_value_q <= '0;
            snap_row_q   <= '0;
            snap_col_q   <= '0;
        end else begin
            beat_valid_q <= accept;
            // follows the cell register stage
            result_valid <= beat_valid_q;
            if (accept) begin
                feat_value_q <= feature_value;
                feat_row_q   <= feature_row;
                feat_col_q   <= feature_col;
                snap_value_q <= weight_value_q;
                snap_row_q   <= weight_row_q;
                snap_col_q   <= weight_col_q;
            end
        end
    end

    // stage 2: outer product grid, weight i by feature j
    for (genvar i = 0; i < NUM_WEIGHTS; i++) begin : g_row
        for (genvar j = 0; j < NUM_FEATURES; j++) begin : g_col
            pe_cell pe_cell_i (
                .clk        (clk),
                .rst        (rst),
                .w_value    (snap_value_q[i]),
                .f_value    (feat_value_q[j]),
                .w_row      (snap_row_q[i]),
                .w_col      (snap_col_q[i]),
                .f_row      (feat_row_q[j]),
                .f_col      (feat_col_q[j]),
                .product    (product[i][j]),
                .row_offset (row_offset[i][j]),
                .col_offset (col_offset[i][j])
            );
        end
    end

endmodule

// ==== design/pe_array_top.sv ====
`timescale 1ns/10ps

module pe_array_top #(
    parameter int NUM_WEIGHTS  = pe_geom_pkg::NUM_WEIGHTS,
    parameter int NUM_FEATURES = pe_geom_pkg::NUM_FEATURES
) (
    input  logic                                                        clk,
    input  logic                                                        rst,

    // weight load port, one weight per beat
    input  logic                                                        weight_valid,
    input  pe_types_pkg::value_t                                        weight_value,
    input  pe_types_pkg::coord_t                                        weight_row,
    input  pe_types_pkg::coord_t                                        weight_col,

    // feature stream, no back-pressure
    input  logic                                                        feature_valid,
    input  pe_types_pkg::value_t [NUM_FEATURES-1:0]                     feature_value,
    input  pe_types_pkg::coord_t [NUM_FEATURES-1:0]                     feature_row,
    input  pe_types_pkg::coord_t [NUM_FEATURES-1:0]                     feature_col,

    // indexed [weight][feature]
    output logic                                                        result_valid,
    output pe_types_pkg::product_t [NUM_WEIGHTS-1:0][NUM_FEATURES-1:0]  product,
    output pe_types_pkg::coord_t [NUM_WEIGHTS-1:0][NUM_FEATURES-1:0]    row_offset,
    output pe_types_pkg::coord_t [NUM_WEIGHTS-1:0][NUM_FEATURES-1:0]    col_offset
);

    pe_types_pkg::value_t [NUM_WEIGHTS-1:0] weight_value_q;
    pe_types_pkg::coord_t [NUM_WEIGHTS-1:0] weight_row_q;
    pe_types_pkg::coord_t [NUM_WEIGHTS-1:0] weight_col_q;
    logic                                   weights_full;

    weight_buffer #(
        .NUM_WEIGHTS    (NUM_WEIGHTS)
    ) weight_buffer_i (
        .clk            (clk),
        .rst            (rst),
        .weight_valid   (weight_valid),
        .weight_value   (weight_value),
        .weight_row     (weight_row),
        .weight_col     (weight_col),
        .weight_value_q (weight_value_q),
        .weight_row_q   (weight_row_q),
        .weight_col_q   (weight_col_q),
        .weights_full   (weights_full)
    );

    pe_array #(
        .NUM_WEIGHTS    (NUM_WEIGHTS),
        .NUM_FEATURES   (NUM_FEATURES)
    ) pe_array_i (
        .clk            (clk),
        .rst            (rst),
        .feature_valid  (feature_valid),
        .feature_value  (feature_value),
        .feature_row    (feature_row),
        .feature_col    (feature_col),
        .weight_value_q (weight_value_q),
        .weight_row_q   (weight_row_q),
        .weight_col_q   (weight_col_q),
        .weights_full   (weights_full),
        .result_valid   (result_valid),
        .product        (product),
        .row_offset     (row_offset),
        .col_offset     (col_offset)
    );

endmodule

// ==== include/pe_tb_checks.svh ====
`ifndef PE_TB_CHECKS_SVH
`define PE_TB_CHECKS_SVH

// full-precision product of one cell
task automatic check_product(
    input string                  name,
    input pe_types_pkg::product_t got,
    input pe_types_pkg::product_t exp
);
    if (got !== exp) begin
        fail_run($sformatf("ERR %0t %s got %0d expected %0d",
                           $time, name, got, exp));
    end
endtask

// row or column offset, 8-bit wrapped
task automatic check_offset(
    input string                name,
    input pe_types_pkg::coord_t got,
    input pe_types_pkg::coord_t exp
);
    if (got !== exp) begin
        fail_run($sformatf("ERR %0t %s got %0d expected %0d",
                           $time, name, got, exp));
    end
endtask

`endif

// ==== dv/pe_tb.sv ====
`timescale 1ns/10ps

module pe_tb;

    localparam int    NW        = pe_geom_pkg::NUM_WEIGHTS;
    localparam int    NF        = pe_geom_pkg::NUM_FEATURES;
    localparam string STIM_FILE = "dv/pe_stim.txt";

    logic                                          clk;
    logic                                          rst;
    logic                                          weight_valid;
    pe_types_pkg::value_t                          weight_value;
    pe_types_pkg::coord_t                          weight_row;
    pe_types_pkg::coord_t                          weight_col;
    logic                                          feature_valid;
    pe_types_pkg::value_t [NF-1:0]                 feature_value;
    pe_types_pkg::coord_t [NF-1:0]                 feature_row;
    pe_types_pkg::coord_t [NF-1:0]                 feature_col;
    logic                                          result_valid;
    pe_types_pkg::product_t [NW-1:0][NF-1:0]       product;
    pe_types_pkg::coord_t [NW-1:0][NF-1:0]         row_offset;
    pe_types_pkg::coord_t [NW-1:0][NF-1:0]         col_offset;

    // expected results, in acceptance order
    pe_types_pkg::product_t [NW-1:0][NF-1:0]       exp_prod_q[$];
    pe_types_pkg::coord_t [NW-1:0][NF-1:0]         exp_row_q[$];
    pe_types_pkg::coord_t [NW-1:0][NF-1:0]         exp_col_q[$];
    int                                            exp_cycle_q[$];

    int          cyc = 0;
    int          num_lines = 0;
    logic [31:0] lfsr;

    pe_array_top #(
        .NUM_WEIGHTS   (NW),
        .NUM_FEATURES  (NF)
    ) pe_array_top_i (
        .clk           (clk),
        .rst           (rst),
        .weight_valid  (weight_valid),
        .weight_value  (weight_value),
        .weight_row    (weight_row),
        .weight_col    (weight_col),
        .feature_valid (feature_valid),
        .feature_value (feature_value),
        .feature_row   (feature_row),
        .feature_col   (feature_col),
        .result_valid  (result_valid),
        .product       (product),
        .row_offset    (row_offset),
        .col_offset    (col_offset)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    `include "pe_tb_checks.svh"

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // posedge count, read at negedge by the scoreboard
    always @(posedge clk) cyc <= cyc + 1;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // 0 to 3 idle cycles, one LFSR step per bit
    task automatic draw_gap(output int n);
        n = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            n = (n << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            weight_valid  <= 1'b0;
            feature_valid <= 1'b0;
        end
    endtask

    task automatic count_lines(output int n);
        int               fd;
        logic [8*256-1:0] line;
        n = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) fail_run("could not open the stimulus file");
        while ($fgets(line, fd) != 0) n++;
        $fclose(fd);
    endtask

    // pops one expected entry and compares all cells
    task automatic compare_result();
        pe_types_pkg::product_t [NW-1:0][NF-1:0] ep;
        pe_types_pkg::coord_t [NW-1:0][NF-1:0]   er;
        pe_types_pkg::coord_t [NW-1:0][NF-1:0]   ec;
        int                                      ecyc;
        if (exp_cycle_q.size() == 0) begin
            fail_run("result_valid went high with no accepted feature beat outstanding");
        end
        ep = exp_prod_q.pop_front();
        er = exp_row_q.pop_front();
        ec = exp_col_q.pop_front();
        ecyc = exp_cycle_q.pop_front();
        if (cyc != ecyc) begin
            fail_run($sformatf("result arrived in cycle %0d but was due in cycle %0d",
                               cyc, ecyc));
        end
        for (int i = 0; i < NW; i++) begin
            for (int j = 0; j < NF; j++) begin
                check_product($sformatf("product[%0d][%0d]", i, j), product[i][j], ep[i][j]);
                check_offset($sformatf("row_offset[%0d][%0d]", i, j),
                             row_offset[i][j], er[i][j]);
                check_offset($sformatf("col_offset[%0d][%0d]", i, j),
                             col_offset[i][j], ec[i][j]);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && result_valid) compare_result();
    end

    initial begin
        wait (num_lines > 0);
        repeat (num_lines * 5 + 100) @(posedge clk);
        fail_run("watchdog expired before the stimulus finished");
    end

    initial begin
        int                                      fd;
        int                                      code;
        int                                      row;
        int                                      gap;
        int                                      gap_en;
        int                                      drive_cyc;
        int                                      vals [3*NF];
        logic [8*8-1:0]                          tok;
        logic [8*256-1:0]                        rest;
        pe_types_pkg::product_t [NW-1:0][NF-1:0] cur_prod;
        pe_types_pkg::coord_t [NW-1:0][NF-1:0]   cur_row;
        pe_types_pkg::coord_t [NW-1:0][NF-1:0]   cur_col;

        lfsr          = 32'hf9bd8853;
        drive_cyc     = 0;
        rst           = 1'b1;
        weight_valid  = 1'b0;
        weight_value  = '0;
        weight_row    = '0;
        weight_col    = '0;
        feature_valid = 1'b0;
        feature_value = '0;
        feature_row   = '0;
        feature_col   = '0;
        cur_prod      = '0;
        cur_row       = '0;
        cur_col       = '0;

        count_lines(num_lines);
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) fail_run("could not open the stimulus file");

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        while (!$feof(fd)) begin
            tok = '0;
            code = $fscanf(fd, "%s", tok);
            if (code != 1) break;
            if (tok == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "W") begin
                code = $fscanf(fd, "%d %d %d", vals[0], vals[1], vals[2]);
                if (code != 3) fail_run("malformed weight line in the stimulus file");
                draw_gap(gap);
                idle_cycles(gap);
                @(posedge clk);
                weight_valid  <= 1'b1;
                weight_value  <= pe_types_pkg::value_t'(vals[0]);
                weight_row    <= pe_types_pkg::coord_t'(vals[1]);
                weight_col    <= pe_types_pkg::coord_t'(vals[2]);
                feature_valid <= 1'b0;
            end else if (tok == "F") begin
                code = $fscanf(fd, "%d", gap_en);
                for (int k = 0; k < 3 * NF; k++) code += $fscanf(fd, "%d", vals[k]);
                if (code != 1 + 3 * NF) fail_run("malformed feature line in the stimulus file");
                if (gap_en != 0) begin
                    draw_gap(gap);
                    idle_cycles(gap);
                end
                @(posedge clk);
                drive_cyc = cyc;
                weight_valid  <= 1'b0;
                feature_valid <= 1'b1;
                for (int j = 0; j < NF; j++) begin
                    feature_value[j] <= pe_types_pkg::value_t'(vals[3*j]);
                    feature_row[j]   <= pe_types_pkg::coord_t'(vals[3*j+1]);
                    feature_col[j]   <= pe_types_pkg::coord_t'(vals[3*j+2]);
                end
            end else if (tok == "E") begin
                code = $fscanf(fd, "%d", row);
                for (int k = 0; k < 3 * NF; k++) code += $fscanf(fd, "%d", vals[k]);
                if (code != 1 + 3 * NF || row < 0 || row >= NW) begin
                    fail_run("malformed expected line in the stimulus file");
                end
                for (int j = 0; j < NF; j++) begin
                    cur_prod[row][j] = pe_types_pkg::product_t'(vals[3*j]);
                    cur_row[row][j]  = pe_types_pkg::coord_t'(vals[3*j+1]);
                    cur_col[row][j]  = pe_types_pkg::coord_t'(vals[3*j+2]);
                end
                // drive edge, accept edge, cell edge, then the negedge sample
                if (row == NW - 1) begin
                    exp_prod_q.push_back(cur_prod);
                    exp_row_q.push_back(cur_row);
                    exp_col_q.push_back(cur_col);
                    exp_cycle_q.push_back(drive_cyc + 3);
                end
            end else begin
                fail_run("unknown line type in the stimulus file");
            end
        end
        $fclose(fd);

        @(posedge clk);
        weight_valid  <= 1'b0;
        feature_valid <= 1'b0;
        repeat (4) @(negedge clk);

        if (exp_cycle_q.size() != 0) begin
            fail_run($sformatf("%0d expected results never arrived", exp_cycle_q.size()));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== project.f ====
design/pe_types_pkg.sv
design/pe_geom_pkg.sv
design/weight_buffer.sv
design/pe_cell.sv
design/pe_array.sv
design/pe_array_top.sv
+incdir+include
dv/pe_tb.sv

// ==== Makefile ====
# Verilator build for the sparse convolution PE array testbench

TOP := pe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) \
		-o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== dv/pe_stim.txt ====
# W value row col : one weight beat, random gap before it
# F gap v0 r0 c0 v1 r1 c1 v2 r2 c2 v3 r3 c3 : feature beat, gap 0 means next cycle
# E i then product row_off col_off for features 0..3 against weight slot i
# a feature beat with no E lines is expected to be dropped
#
# dropped, buffer empty
F 1 5 5 5 6 6 6 7 7 7 8 8 8
# first three weights
W 3 1 2
W -2 0 -1
W 127 -5 4
# dropped, only three slots filled
F 0 9 9 9 9 9 9 9 9 9 9 9 9
W -128 100 -100
# beat 1, right after the fourth weight
F 0 1 1 2 -1 0 0 2 -3 5 0 10 -10
E 0 3 0 0 -3 -1 -2 6 -4 3 0 9 -12
E 1 -2 1 3 2 0 1 -4 -3 6 0 10 -9
E 2 127 6 -2 -127 5 -4 254 2 1 0 15 -14
E 3 -128 -99 102 128 -100 100 -256 -103 105 0 -90 90
# beat 2, extremes and wrapping offsets
F 1 -128 -128 127 127 127 -128 -1 -100 100 -128 0 0
E 0 -384 127 125 381 126 126 -3 -101 98 -384 -1 -2
E 1 256 -128 -128 -254 127 -127 2 -100 101 256 0 1
E 2 -16256 -123 123 16129 -124 124 -127 -95 96 -16256 5 -4
E 3 16384 28 -29 -16256 27 -28 128 56 -56 16384 -100 100
# beat 3 and beat 4 back to back
F 1 1 1 2 -1 0 0 2 -3 5 0 10 -10
E 0 3 0 0 -3 -1 -2 6 -4 3 0 9 -12
E 1 -2 1 3 2 0 1 -4 -3 6 0 10 -9
E 2 127 6 -2 -127 5 -4 254 2 1 0 15 -14
E 3 -128 -99 102 128 -100 100 -256 -103 105 0 -90 90
F 0 -128 -128 127 127 127 -128 -1 -100 100 -128 0 0
E 0 -384 127 125 381 126 126 -3 -101 98 -384 -1 -2
E 1 256 -128 -128 -254 127 -127 2 -100 101 256 0 1
E 2 -16256 -123 123 16129 -124 124 -127 -95 96 -16256 5 -4
E 3 16384 28 -29 -16256 27 -28 128 56 -56 16384 -100 100
# fifth weight wraps into slot 0
W -1 2 -3
# beat 5, only row 0 changes
F 0 1 1 2 -1 0 0 2 -3 5 0 10 -10
E 0 -1 -1 5 1 -2 3 -2 -5 8 0 8 -7
E 1 -2 1 3 2 0 1 -4 -3 6 0 10 -9
E 2 127 6 -2 -127 5 -4 254 2 1 0 15 -14
E 3 -128 -99 102 128 -100 100 -256 -103 105 0 -90 90
# beat 6 and beat 7 back to back with the new slot 0
F 1 -128 -128 127 127 127 -128 -1 -100 100 -128 0 0
E 0 128 126 -126 -127 125 -125 1 -102 103 128 -2 3
E 1 256 -128 -128 -254 127 -127 2 -100 101 256 0 1
E 2 -16256 -123 123 16129 -124 124 -127 -95 96 -16256 5 -4
E 3 16384 28 -29 -16256 27 -28 128 56 -56 16384 -100 100
F 0 1 1 2 -1 0 0 2 -3 5 0 10 -10
E 0 -1 -1 5 1 -2 3 -2 -5 8 0 8 -7
E 1 -2 1 3 2 0 1 -4 -3 6 0 10 -9
E 2 127 6 -2 -127 5 -4 254 2 1 0 15 -14
E 3 -128 -99 102 128 -100 100 -256 -103 105 0 -90 90
